/* include/vu_defines.svh */
// --------------------------------------
// size parameters of the vector unit
// included by the package and by any RTL
// file that sizes arrays or lanes
// --------------------------------------

`ifndef VU_DEFINES_SVH
`define VU_DEFINES_SVH

// reservation station depth, power of two
`define VU_NUM_ENTRIES 4

// vector register file size
`define VU_NUM_REGS 8

// lanes per vector and bits per lane
`define VU_NUM_LANES 4
`define VU_LANE_WIDTH 16

`endif

/* run.sh */
#!/usr/bin/env bash
# build the vector unit testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module vu_tb -o vu_sim \
  && ./obj_dir/vu_sim \
  || exit 1

/* sim.f */
+incdir+include
verilog/vu_pkg.sv
verilog/vu_reservation_station.sv
verilog/vu_register_file.sv
verilog/vu_madd_datapath.sv
verilog/vu_top.sv
verification/vu_tb.sv

/* verification/vu_tb.sv */
// --------------------------------------
// testbench for the vector unit: loads
// registers, issues random dependent
// instructions and checks write-backs,
// flags and external reads vs a model
// --------------------------------------

`timescale 1ns/1ps
`include "vu_defines.svh"

module vu_tb import vu_pkg::*; ;

  localparam int NUM_INSTR = 200;
  localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 200;

  // dut inputs
  logic      clk;
  logic      reset;
  logic      insert_i;
  vu_op_t    op_i;
  vreg_idx_t src_a_i;
  vreg_idx_t src_b_i;
  vreg_idx_t dest_i;
  logic      write_dest_i;
  logic      req_a_i;
  logic      req_b_i;
  logic      valid_a_i;
  logic      valid_b_i;
  rs_ref_t   ref_a_i;
  rs_ref_t   ref_b_i;
  logic      ext_en_i;
  logic      ext_we_i;
  vreg_idx_t ext_addr_i;
  vword_t    ext_wdata_i;

  // dut outputs
  logic      full_o;
  logic      empty_o;
  rs_ref_t   insert_ref_o;
  vword_t    ext_rdata_o;
  logic      wb_en_o;
  vreg_idx_t wb_addr_o;
  vword_t    wb_data_o;
  rs_ref_t   wb_ref_o;

  // model state
  logic [31:0] lfsr;
  vword_t shadow [`VU_NUM_REGS];
  logic pend_v [`VU_NUM_REGS];
  rs_ref_t pend_r [`VU_NUM_REGS];
  vreg_idx_t exp_addr_q [$];
  rs_ref_t exp_ref_q [$];
  vword_t exp_data_q [$];
  logic wd_q [$];
  // source registers each unretired instruction reads
  logic [`VU_NUM_REGS-1:0] rd_mask_q [$];
  rs_ref_t ins_ref_cnt;
  int count;
  int cycles;
  logic last_accept;
  logic rd_armed;
  logic rand_rd_en;
  vword_t rd_exp;
  vword_t rd_exp_q;
  vreg_idx_t last_dest;

  vu_top vu_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois lfsr, one step per bit taken
  function automatic logic step_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'hB4BC_D35C;
    return b;
  endfunction

  function automatic vword_t rand_word();
    vword_t w;
    for (int i = 0; i < $bits(vword_t); i++)
      w[i] = step_bit();
    return w;
  endfunction

  function automatic vreg_idx_t rand_idx();
    vreg_idx_t r;
    for (int i = 0; i < $bits(vreg_idx_t); i++)
      r[i] = step_bit();
    return r;
  endfunction

  function automatic logic [1:0] rand2();
    logic [1:0] v;
    v[0] = step_bit();
    v[1] = step_bit();
    return v;
  endfunction

  // lane-wise reference arithmetic, 16-bit wrap
  function automatic vword_t model_op(vu_op_t op, vword_t a, vword_t b);
    logic [15:0] la, lb;
    logic [31:0] prod;
    vword_t r;
    for (int l = 0; l < 4; l++) begin
      la = a[l*16 +: 16];
      lb = b[l*16 +: 16];
      prod = la * lb;
      if (op == VU_OP_ADD)
        r[l*16 +: 16] = la + lb;
      else if (op == VU_OP_SUB)
        r[l*16 +: 16] = la - lb;
      else
        r[l*16 +: 16] = prod[15:0];
    end
    return r;
  endfunction

  // --------------------------------------
  // compare tasks
  // --------------------------------------

  task automatic fail_now();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, vword_t got, vword_t exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_idx(string name, vreg_idx_t got, vreg_idx_t exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_ref(string name, rs_ref_t got, rs_ref_t exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  // --------------------------------------
  // monitor at negedge, inputs are stable
  // --------------------------------------

  always @(negedge clk) begin
    vword_t a, b, r;
    logic [`VU_NUM_REGS-1:0] m;
    if (!reset) begin
      if (rd_armed)
        check_word("ext_rdata_o", ext_rdata_o, rd_exp_q);
      rd_armed = ext_en_i && !ext_we_i;
      rd_exp_q = rd_exp;
      check_bit("full_o", full_o, count == 4);
      check_bit("empty_o", empty_o, count == 0);
      check_ref("insert_ref_o", insert_ref_o, ins_ref_cnt);
      if (wb_en_o) begin
        if (exp_data_q.size() == 0) begin
          $display("write-back seen with no instruction expecting one");
          fail_now();
        end
        check_idx("wb_addr_o", wb_addr_o, exp_addr_q.pop_front());
        check_ref("wb_ref_o", wb_ref_o, exp_ref_q.pop_front());
        check_word("wb_data_o", wb_data_o, exp_data_q.pop_front());
        if (pend_v[wb_addr_o] && pend_r[wb_addr_o] == wb_ref_o)
          pend_v[wb_addr_o] = 1'b0;
      end
      // retire of the head, a write-back only when it writes
      if (vu_top_i.rs_i.ret_done) begin
        check_bit("wb_en_o", wb_en_o, wd_q.pop_front());
        void'(rd_mask_q.pop_front());
        count--;
      end
      last_accept = insert_i && !full_o;
      if (last_accept) begin
        a = req_a_i ? shadow[src_a_i] : '0;
        b = req_b_i ? shadow[src_b_i] : '0;
        r = model_op(op_i, a, b);
        wd_q.push_back(write_dest_i);
        m = '0;
        if (req_a_i)
          m[src_a_i] = 1'b1;
        if (req_b_i)
          m[src_b_i] = 1'b1;
        rd_mask_q.push_back(m);
        if (write_dest_i) begin
          shadow[dest_i] = r;
          pend_v[dest_i] = 1'b1;
          pend_r[dest_i] = ins_ref_cnt;
          exp_addr_q.push_back(dest_i);
          exp_ref_q.push_back(ins_ref_cnt);
          exp_data_q.push_back(r);
        end
        ins_ref_cnt++;
        count++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("TEST FAIL");
      $fatal(1, "timeout, run did not finish within the cycle limit");
    end
  end

  // --------------------------------------
  // stimulus
  // --------------------------------------

  // one cycle step with an optional random external read or write
  task automatic tick();
    vreg_idx_t r;
    logic [1:0] sel;
    logic [`VU_NUM_REGS-1:0] busy;
    r = rand_idx();
    sel = rand2();
    // registers an unretired instruction may still fetch
    busy = '0;
    foreach (rd_mask_q[i])
      busy = busy | rd_mask_q[i];
    ext_en_i = 1'b0;
    if (rand_rd_en && !pend_v[r]) begin
      if (sel == 2'd0) begin
        ext_en_i = 1'b1;
        ext_we_i = 1'b0;
        ext_addr_i = r;
        rd_exp = shadow[r];
      end else if (sel == 2'd1 && step_bit() && !busy[r]) begin
        ext_en_i = 1'b1;
        ext_we_i = 1'b1;
        ext_addr_i = r;
        ext_wdata_i = rand_word();
        shadow[r] = ext_wdata_i;
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic ext_write(vreg_idx_t addr, vword_t data);
    ext_en_i = 1'b1;
    ext_we_i = 1'b1;
    ext_addr_i = addr;
    ext_wdata_i = data;
    shadow[addr] = data;
    @(posedge clk);
    #1;
    ext_en_i = 1'b0;
  endtask

  task automatic wait_empty();
    while (!empty_o || exp_data_q.size() != 0)
      tick();
  endtask

  // operand flags follow the current pending producers
  task automatic drive_operands();
    valid_a_i = !pend_v[src_a_i];
    ref_a_i = pend_r[src_a_i];
    valid_b_i = !pend_v[src_b_i];
    ref_b_i = pend_r[src_b_i];
  endtask

  task automatic issue_instr();
    logic [1:0] o;
    o = rand2();
    op_i = vu_op_t'((o == 2'd3) ? 2'd2 : o);
    // half the sources chain onto the last result
    src_a_i = step_bit() ? last_dest : rand_idx();
    src_b_i = step_bit() ? last_dest : rand_idx();
    dest_i = rand_idx();
    write_dest_i = (rand2() != 2'd0) || step_bit();
    req_a_i = (rand2() != 2'd0) || step_bit();
    req_b_i = rand2() != 2'd0;
    if (write_dest_i)
      last_dest = dest_i;
    insert_i = 1'b1;
    last_accept = 1'b0;
    while (!last_accept) begin
      drive_operands();
      tick();
    end
    insert_i = 1'b0;
  endtask

  initial begin
    lfsr = 32'h9084;
    insert_i = 1'b0;
    write_dest_i = 1'b0;
    req_a_i = 1'b0;
    req_b_i = 1'b0;
    valid_a_i = 1'b0;
    valid_b_i = 1'b0;
    op_i = VU_OP_ADD;
    src_a_i = '0;
    src_b_i = '0;
    dest_i = '0;
    ext_addr_i = '0;
    last_dest = '0;
    ref_a_i = '0;
    ref_b_i = '0;
    ins_ref_cnt = '0;
    ext_en_i = 1'b0;
    ext_we_i = 1'b0;
    rd_armed = 1'b0;
    last_accept = 1'b0;
    rand_rd_en = 1'b0;
    ext_wdata_i = '0;
    rd_exp = '0;
    rd_exp_q = '0;
    count = 0;
    cycles = 0;
    for (int i = 0; i < `VU_NUM_REGS; i++) begin
      pend_v[i] = 1'b0;
      pend_r[i] = '0;
    end
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < `VU_NUM_REGS; i++)
      ext_write(vreg_idx_t'(i), rand_word());

    rand_rd_en = 1'b1;
    for (int n = 0; n < NUM_INSTR; n++) begin
      issue_instr();
      // occasional external loads into a drained unit
      if (n % 25 == 24) begin
        wait_empty();
        ext_write(rand_idx(), rand_word());
        ext_write(rand_idx(), rand_word());
      end
    end
    wait_empty();
    rand_rd_en = 1'b0;

    // final readback of the whole register file
    for (int i = 0; i < `VU_NUM_REGS; i++) begin
      ext_en_i = 1'b1;
      ext_we_i = 1'b0;
      ext_addr_i = vreg_idx_t'(i);
      rd_exp = shadow[i];
      @(posedge clk);
      #1;
    end
    ext_en_i = 1'b0;
    tick();
    tick();

    if (wd_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("instructions left unretired at the end of the run");
      $display("TEST FAIL");
      $fatal(1, "unretired instructions");
    end
  end

endmodule

/* verilog/vu_madd_datapath.sv */
// --------------------------------------
// lane-wise add/sub/mul datapath, operand
// registers fed from the register file and
// a two-stage pipeline frozen by stall
// --------------------------------------

`timescale 1ns/1ps
`include "vu_defines.svh"

module vu_madd_datapath import vu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  vword_t vrf_rdata_i,
  input  logic   reg_in_a_i,
  input  logic   reg_in_b_i,
  input  logic   ctl_valid_i,
  input  vu_op_t ctl_op_i,
  input  logic   stall_i,
  output logic   result_avail_o,
  output vword_t result_o
);

  vword_t op_a;
  vword_t op_b;
  vword_t s1_res;
  logic   s1_valid;

  // per-lane op, results wrap at lane width
  function automatic vword_t lane_op(vu_op_t op, vword_t a, vword_t b);
    lane_t  la;
    lane_t  lb;
    lane_t  lr;
    vword_t res;

    res = '0;
    for (int l = 0; l < `VU_NUM_LANES; l++) begin
      la = a[l*`VU_LANE_WIDTH +: `VU_LANE_WIDTH];
      lb = b[l*`VU_LANE_WIDTH +: `VU_LANE_WIDTH];
      case (op)
        VU_OP_ADD: lr = la + lb;
        VU_OP_SUB: lr = la - lb;
        // low half of the product only
        default:   lr = la * lb;
      endcase
      res[l*`VU_LANE_WIDTH +: `VU_LANE_WIDTH] = lr;
    end
    return res;
  endfunction

  // --------------------------------------
  // operand registers
  // --------------------------------------

  // consumed operands clear, so an unfetched one is zero
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_a <= '0;
      op_b <= '0;
    end else begin
      if (reg_in_a_i)
        op_a <= vrf_rdata_i;
      else if (ctl_valid_i && !stall_i)
        op_a <= '0;

      if (reg_in_b_i)
        op_b <= vrf_rdata_i;
      else if (ctl_valid_i && !stall_i)
        op_b <= '0;
    end
  end

  // --------------------------------------
  // pipeline stages
  // --------------------------------------

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s1_valid       <= 1'b0;
      result_avail_o <= 1'b0;
    end else if (!stall_i) begin
      s1_valid       <= ctl_valid_i;
      result_avail_o <= s1_valid;
    end
  end

  // stage one computes, stage two holds the result
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      s1_res   <= lane_op(ctl_op_i, op_a, op_b);
      result_o <= s1_res;
    end
  end

endmodule

/* verilog/vu_pkg.sv */
// --------------------------------------
// shared types of the vector unit
// imported by every RTL module and the
// testbench with a wildcard import
// --------------------------------------

`include "vu_defines.svh"

package vu_pkg;

  // vector register index
  typedef logic [$clog2(`VU_NUM_REGS)-1:0] vreg_idx_t;

  // one lane and one full vector
  typedef logic [`VU_LANE_WIDTH-1:0] lane_t;
  typedef logic [`VU_NUM_LANES*`VU_LANE_WIDTH-1:0] vword_t;

  // reference to a reservation station entry
  typedef logic [$clog2(`VU_NUM_ENTRIES)-1:0] rs_ref_t;

  // multiply-add unit operations
  // mul keeps the low half of each lane product
  typedef enum logic [1:0] {
    VU_OP_ADD = 2'd0,
    VU_OP_SUB = 2'd1,
    VU_OP_MUL = 2'd2
  } vu_op_t;

endpackage

/* verilog/vu_register_file.sv */
// --------------------------------------
// vector register file with one station
// port, an external load/read port that
// wins arbitration, and the wb broadcast
// --------------------------------------

`timescale 1ns/1ps
`include "vu_defines.svh"

module vu_register_file import vu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // station port
  input  logic      vrf_req_i,
  input  logic      vrf_we_i,
  input  vreg_idx_t vrf_addr_i,
  input  vword_t    vrf_wdata_i,
  input  rs_ref_t   vrf_ref_i,
  output logic      vrf_ack_o,
  output vword_t    vrf_rdata_o,
  // external port
  input  logic      ext_en_i,
  input  logic      ext_we_i,
  input  vreg_idx_t ext_addr_i,
  input  vword_t    ext_wdata_i,
  output vword_t    ext_rdata_o,
  // write-back broadcast
  output logic      wb_en_o,
  output vreg_idx_t wb_addr_o,
  output rs_ref_t   wb_ref_o,
  output vword_t    wb_data_o
);

  vword_t regs [`VU_NUM_REGS];
  logic   vrf_wr;

  // external access holds off the station
  assign vrf_ack_o = vrf_req_i && !ext_en_i;
  assign vrf_wr    = vrf_ack_o && vrf_we_i;

  // only one writer per cycle by arbitration
  always_ff @(posedge clk) begin
    if (ext_en_i && ext_we_i)
      regs[ext_addr_i] <= ext_wdata_i;
    else if (vrf_wr)
      regs[vrf_addr_i] <= vrf_wdata_i;
  end

  // read data one cycle after the access
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vrf_rdata_o <= '0;
      ext_rdata_o <= '0;
    end else begin
      if (ext_en_i && !ext_we_i)
        ext_rdata_o <= regs[ext_addr_i];
      if (vrf_ack_o && !vrf_we_i)
        vrf_rdata_o <= regs[vrf_addr_i];
    end
  end

  // broadcast in the write cycle, station writes only
  assign wb_en_o   = vrf_wr;
  assign wb_addr_o = vrf_addr_i;
  assign wb_ref_o  = vrf_ref_i;
  assign wb_data_o = vrf_wdata_i;

endmodule

/* verilog/vu_reservation_station.sv */
// --------------------------------------
// in-order reservation station for the
// multiply-add datapath: entry ring, wb
// listener, operand fetch and in-order
// retire over one shared register port
// --------------------------------------

`timescale 1ns/1ps
`include "vu_defines.svh"

module vu_reservation_station import vu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // issue side
  input  logic      insert_i,
  input  vu_op_t    op_i,
  input  vreg_idx_t src_a_i,
  input  vreg_idx_t src_b_i,
  input  vreg_idx_t dest_i,
  input  logic      write_dest_i,
  input  logic      req_a_i,
  input  logic      req_b_i,
  input  logic      valid_a_i,
  input  logic      valid_b_i,
  input  rs_ref_t   ref_a_i,
  input  rs_ref_t   ref_b_i,
  output logic      full_o,
  output logic      empty_o,
  output rs_ref_t   insert_ref_o,
  // shared register file port
  output logic      vrf_req_o,
  output logic      vrf_we_o,
  output vreg_idx_t vrf_addr_o,
  output vword_t    vrf_wdata_o,
  output rs_ref_t   vrf_ref_o,
  input  logic      vrf_ack_i,
  // write-back broadcast
  input  logic      wb_en_i,
  input  rs_ref_t   wb_ref_i,
  // datapath control
  output logic      reg_in_a_o,
  output logic      reg_in_b_o,
  output logic      ctl_valid_o,
  output vu_op_t    ctl_op_o,
  output logic      stall_o,
  input  logic      result_avail_i,
  input  vword_t    result_i
);

  // --------------------------------------
  // local types
  // --------------------------------------

  // entry index plus wrap bit on top
  localparam int PTR_W = $bits(rs_ref_t) + 1;
  typedef logic [PTR_W-1:0] rs_ptr_t;

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_REQ_A,
    EX_REQ_B,
    EX_ISSUE
  } ex_state_t;

  typedef enum logic {
    RET_IDLE,
    RET_REQ
  } ret_state_t;

  // --------------------------------------
  // entry storage and pointers
  // --------------------------------------

  vu_op_t    ent_op    [`VU_NUM_ENTRIES];
  vreg_idx_t ent_src_a [`VU_NUM_ENTRIES];
  vreg_idx_t ent_src_b [`VU_NUM_ENTRIES];
  vreg_idx_t ent_dest  [`VU_NUM_ENTRIES];
  logic      ent_wd    [`VU_NUM_ENTRIES];
  logic      ent_req_a [`VU_NUM_ENTRIES];
  logic      ent_req_b [`VU_NUM_ENTRIES];
  // operand ready: valid, or not required at all
  logic      ent_val_a [`VU_NUM_ENTRIES];
  logic      ent_val_b [`VU_NUM_ENTRIES];
  rs_ref_t   ent_ref_a [`VU_NUM_ENTRIES];
  rs_ref_t   ent_ref_b [`VU_NUM_ENTRIES];

  rs_ptr_t ins_ptr;
  rs_ptr_t ex_ptr;
  rs_ptr_t ret_ptr;
  rs_ref_t ins_idx;
  rs_ref_t ex_idx;
  rs_ref_t ret_idx;

  logic accept;
  logic ex_pending;
  logic hit_a;
  logic hit_b;

  ex_state_t  ex_state;
  ex_state_t  ex_state_d;
  ret_state_t ret_state;

  // execute side
  logic      ex_req;
  logic      ex_ack;
  logic      ex_issue;
  vreg_idx_t ex_addr;
  logic      next_reg_in_a;
  logic      next_reg_in_b;

  // retire side
  logic ret_req;
  logic ret_ack;
  logic ret_done;

  assign ins_idx = ins_ptr[PTR_W-2:0];
  assign ex_idx  = ex_ptr[PTR_W-2:0];
  assign ret_idx = ret_ptr[PTR_W-2:0];

  assign insert_ref_o = ins_idx;

  // full when insert has lapped retire once
  assign full_o     = (ins_idx == ret_idx) && (ins_ptr[PTR_W-1] != ret_ptr[PTR_W-1]);
  assign empty_o    = (ins_ptr == ret_ptr);
  assign ex_pending = (ins_ptr != ex_ptr);
  assign accept     = insert_i && !full_o;

  // producer broadcasting in the insert cycle itself
  assign hit_a = wb_en_i && (wb_ref_i == ref_a_i);
  assign hit_b = wb_en_i && (wb_ref_i == ref_b_i);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ins_ptr <= '0;
      ex_ptr  <= '0;
      ret_ptr <= '0;
    end else begin
      if (accept)
        ins_ptr <= ins_ptr + 1'b1;
      if (ex_issue)
        ex_ptr <= ex_ptr + 1'b1;
      if (ret_done)
        ret_ptr <= ret_ptr + 1'b1;
    end
  end

  // --------------------------------------
  // insert and wb listener
  // --------------------------------------

  always_ff @(posedge clk) begin
    // per-entry listeners, stale refs only re-set a set flag
    for (int i = 0; i < `VU_NUM_ENTRIES; i++) begin
      if (wb_en_i && (wb_ref_i == ent_ref_a[i]))
        ent_val_a[i] <= 1'b1;
      if (wb_en_i && (wb_ref_i == ent_ref_b[i]))
        ent_val_b[i] <= 1'b1;
    end

    // new entry overrides the listener on its own slot
    if (accept) begin
      ent_op[ins_idx]    <= op_i;
      ent_src_a[ins_idx] <= src_a_i;
      ent_src_b[ins_idx] <= src_b_i;
      ent_dest[ins_idx]  <= dest_i;
      ent_wd[ins_idx]    <= write_dest_i;
      ent_req_a[ins_idx] <= req_a_i;
      ent_req_b[ins_idx] <= req_b_i;
      ent_val_a[ins_idx] <= valid_a_i || !req_a_i || hit_a;
      ent_val_b[ins_idx] <= valid_b_i || !req_b_i || hit_b;
      ent_ref_a[ins_idx] <= ref_a_i;
      ent_ref_b[ins_idx] <= ref_b_i;
    end
  end

  // --------------------------------------
  // execute state machine
  // --------------------------------------

  // port is requested in both fetch states
  assign ex_req = (ex_state == EX_REQ_A) || (ex_state == EX_REQ_B);
  assign ex_ack = vrf_ack_i && !ret_req;

  always_comb begin
    ex_state_d    = ex_state;
    ex_addr       = ent_src_a[ex_idx];
    ex_issue      = 1'b0;
    next_reg_in_a = 1'b0;
    next_reg_in_b = 1'b0;

    case (ex_state)
      EX_IDLE: begin
        // oldest unissued entry with both operands ready
        if (ex_pending && !stall_o && ent_val_a[ex_idx] && ent_val_b[ex_idx]) begin
          if (ent_req_a[ex_idx])
            ex_state_d = EX_REQ_A;
          else if (ent_req_b[ex_idx])
            ex_state_d = EX_REQ_B;
          else
            ex_state_d = EX_ISSUE;
        end
      end

      EX_REQ_A: begin
        next_reg_in_a = ex_ack;
        if (ex_ack)
          ex_state_d = ent_req_b[ex_idx] ? EX_REQ_B : EX_ISSUE;
      end

      EX_REQ_B: begin
        ex_addr       = ent_src_b[ex_idx];
        next_reg_in_b = ex_ack;
        if (ex_ack)
          ex_state_d = EX_ISSUE;
      end

      EX_ISSUE: begin
        // pending retire blocks issue
        if (!stall_o) begin
          ex_issue   = 1'b1;
          ex_state_d = EX_IDLE;
        end
      end

      default: begin
        ex_state_d = EX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_state    <= EX_IDLE;
      reg_in_a_o  <= 1'b0;
      reg_in_b_o  <= 1'b0;
      ctl_valid_o <= 1'b0;
    end else begin
      ex_state <= ex_state_d;
      // enables line up with read data one cycle after ack
      reg_in_a_o <= next_reg_in_a;
      reg_in_b_o <= next_reg_in_b;
      if (!stall_o)
        ctl_valid_o <= ex_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_issue)
      ctl_op_o <= ent_op[ex_idx];
  end

  // --------------------------------------
  // retire state machine
  // --------------------------------------

  // result at the head wants the port until acked
  assign ret_req = (ret_state == RET_REQ) || (result_avail_i && ent_wd[ret_idx]);
  assign ret_ack = vrf_ack_i && ret_req;

  // datapath frozen while the write-back waits
  assign stall_o = ret_req && !ret_ack;

  // no-destination results retire on result_avail
  assign ret_done = ret_ack
                 || ((ret_state == RET_IDLE) && result_avail_i && !ent_wd[ret_idx]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ret_state <= RET_IDLE;
    end else begin
      case (ret_state)
        RET_IDLE: begin
          if (ret_req && !ret_ack)
            ret_state <= RET_REQ;
        end
        RET_REQ: begin
          if (ret_ack)
            ret_state <= RET_IDLE;
        end
        default: begin
          ret_state <= RET_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------
  // port mux, retire first
  // --------------------------------------

  always_comb begin
    vrf_req_o   = ret_req || ex_req;
    vrf_we_o    = ret_req;
    vrf_addr_o  = ret_req ? ent_dest[ret_idx] : ex_addr;
    // write data held by the stall
    vrf_wdata_o = result_i;
    vrf_ref_o   = ret_idx;
  end

endmodule

/* verilog/vu_top.sv */
// --------------------------------------
// vector unit top: reservation station,
// register file and madd datapath wired
// together; the testbench drives issue
// --------------------------------------

`timescale 1ns/1ps

module vu_top import vu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  // issue side
  input  logic      insert_i,
  input  vu_op_t    op_i,
  input  vreg_idx_t src_a_i,
  input  vreg_idx_t src_b_i,
  input  vreg_idx_t dest_i,
  input  logic      write_dest_i,
  input  logic      req_a_i,
  input  logic      req_b_i,
  input  logic      valid_a_i,
  input  logic      valid_b_i,
  input  rs_ref_t   ref_a_i,
  input  rs_ref_t   ref_b_i,
  output logic      full_o,
  output logic      empty_o,
  output rs_ref_t   insert_ref_o,
  // external register port
  input  logic      ext_en_i,
  input  logic      ext_we_i,
  input  vreg_idx_t ext_addr_i,
  input  vword_t    ext_wdata_i,
  output vword_t    ext_rdata_o,
  // write-back broadcast
  output logic      wb_en_o,
  output vreg_idx_t wb_addr_o,
  output vword_t    wb_data_o,
  output rs_ref_t   wb_ref_o
);

  // station to register file
  logic      vrf_req;
  logic      vrf_we;
  vreg_idx_t vrf_addr;
  vword_t    vrf_wdata;
  rs_ref_t   vrf_ref;
  logic      vrf_ack;
  vword_t    vrf_rdata;

  // station to datapath
  logic   reg_in_a;
  logic   reg_in_b;
  logic   ctl_valid;
  vu_op_t ctl_op;
  logic   stall;
  logic   result_avail;
  vword_t result;

  vu_reservation_station rs_i (
    .clk            (clk),
    .reset          (reset),
    .insert_i       (insert_i),
    .op_i           (op_i),
    .src_a_i        (src_a_i),
    .src_b_i        (src_b_i),
    .dest_i         (dest_i),
    .write_dest_i   (write_dest_i),
    .req_a_i        (req_a_i),
    .req_b_i        (req_b_i),
    .valid_a_i      (valid_a_i),
    .valid_b_i      (valid_b_i),
    .ref_a_i        (ref_a_i),
    .ref_b_i        (ref_b_i),
    .full_o         (full_o),
    .empty_o        (empty_o),
    .insert_ref_o   (insert_ref_o),
    .vrf_req_o      (vrf_req),
    .vrf_we_o       (vrf_we),
    .vrf_addr_o     (vrf_addr),
    .vrf_wdata_o    (vrf_wdata),
    .vrf_ref_o      (vrf_ref),
    .vrf_ack_i      (vrf_ack),
    .wb_en_i        (wb_en_o),
    .wb_ref_i       (wb_ref_o),
    .reg_in_a_o     (reg_in_a),
    .reg_in_b_o     (reg_in_b),
    .ctl_valid_o    (ctl_valid),
    .ctl_op_o       (ctl_op),
    .stall_o        (stall),
    .result_avail_i (result_avail),
    .result_i       (result)
  );

  vu_register_file vrf_i (
    .clk         (clk),
    .reset       (reset),
    .vrf_req_i   (vrf_req),
    .vrf_we_i    (vrf_we),
    .vrf_addr_i  (vrf_addr),
    .vrf_wdata_i (vrf_wdata),
    .vrf_ref_i   (vrf_ref),
    .vrf_ack_o   (vrf_ack),
    .vrf_rdata_o (vrf_rdata),
    .ext_en_i    (ext_en_i),
    .ext_we_i    (ext_we_i),
    .ext_addr_i  (ext_addr_i),
    .ext_wdata_i (ext_wdata_i),
    .ext_rdata_o (ext_rdata_o),
    .wb_en_o     (wb_en_o),
    .wb_addr_o   (wb_addr_o),
    .wb_ref_o    (wb_ref_o),
    .wb_data_o   (wb_data_o)
  );

  vu_madd_datapath dp_i (
    .clk            (clk),
    .reset          (reset),
    .vrf_rdata_i    (vrf_rdata),
    .reg_in_a_i     (reg_in_a),
    .reg_in_b_i     (reg_in_b),
    .ctl_valid_i    (ctl_valid),
    .ctl_op_i       (ctl_op),
    .stall_i        (stall),
    .result_avail_o (result_avail),
    .result_o       (result)
  );

endmodule
